// File: rtl/pdp8_isa_pkg.sv
// PDP-8 instruction set types and field positions for a 4K word machine
// Only page zero, current page and one-level indirect addressing are decoded
package pdp8_isa_pkg;

  typedef logic [11:0] word_t;
  typedef logic [11:0] addr_t;
  typedef logic [6:0]  page_off_t;   // Word offset inside a 128-word page

  typedef enum logic [2:0] {
    OP_AND = 3'o0,
    OP_TAD = 3'o1,
    OP_ISZ = 3'o2,
    OP_DCA = 3'o3,
    OP_JMS = 3'o4,
    OP_JMP = 3'o5,
    OP_IOT = 3'o6,
    OP_OPR = 3'o7
  } opcode_t;

  // Group-2 operate with only the halt bit set
  localparam word_t HALT_WORD = 12'o7402;

  // Memory reference fields
  localparam int IND_BIT  = 8;
  localparam int PAGE_BIT = 7;

  // Group-1 operate microinstruction bits
  localparam int CLA_BIT = 7;
  localparam int CLL_BIT = 6;
  localparam int CMA_BIT = 5;
  localparam int CML_BIT = 4;
  localparam int IAC_BIT = 0;

endpackage

// File: rtl/pdp8_ctrl_pkg.sv
// Controller states and the control words exchanged by the FSM, datapath and memory
// Each select enum keeps its no-change code at zero so an all-zero control word is idle
package pdp8_ctrl_pkg;

  typedef enum logic [5:0] {
    REG_INIT, CPU_IDLE, SR_CHG_1, SR_CHG_2,
    FETCH_1, FETCH_2, FETCH_3, DECODE,
    LD_PC_1, DEP_1, DEP_2,
    CAL_EA_1, EA_IND_1, EA_IND_2,
    AND_1, AND_2, AND_3,
    TAD_1, TAD_2, TAD_3,
    ISZ_1, ISZ_2, ISZ_3, ISZ_4, ISZ_5, ISZ_6,
    DCA_1, DCA_2, DCA_3,
    JMS_1, JMS_2, JMS_3,
    JMP_1, MIC_1, HALT
  } ctrl_state_t;

  typedef enum logic [2:0] {AC_NC, AC_CLEAR, AC_AND, AC_TAD, AC_MICRO} ac_sel_t;
  typedef enum logic       {LK_NC, LK_ZERO} lk_sel_t;
  typedef enum logic [2:0] {PC_NC, PC_SR, PC_P1, PC_P2, PC_JMP} pc_sel_t;
  typedef enum logic [2:0] {MB_NC, MB_ZERO, MB_RD, MB_INC, MB_WD} mb_sel_t;
  typedef enum logic [2:0] {EA_NC, EA_ZERO, EA_PG0, EA_CURPG, EA_IND} ea_sel_t;
  typedef enum logic [1:0] {AD_NC, AD_SR, AD_PC, AD_EA} ad_sel_t;
  typedef enum logic [2:0] {WD_NC, WD_SR, WD_MB, WD_AC, WD_PCP1} wd_sel_t;

  typedef struct packed {
    ac_sel_t ac_sel;
    lk_sel_t lk_sel;
    pc_sel_t pc_sel;
    mb_sel_t mb_sel;
    ea_sel_t ea_sel;
    ad_sel_t ad_sel;
    wd_sel_t wd_sel;
    logic    ir_load;    // IR takes MB
  } dp_ctrl_t;

  typedef struct packed {
    logic read_enable;
    logic write_enable;
  } mem_req_t;

  typedef enum logic [1:0] {DISP_PC, DISP_AC, DISP_MB} disp_sel_t;

  typedef struct packed {
    pdp8_isa_pkg::word_t ir;
    logic                mb_zero;
  } dp_status_t;

endpackage

// File: rtl/pdp8_controller.sv
// Moore sequencer for panel functions and instructions; run continues until HLT
// Panel strobes are honored only in CPU_IDLE, priority run, srchange, loadpc, deposit
`timescale 1ns/100ps

module pdp8_controller (
  input  logic                      clock,
  input  logic                      resetN,
  input  logic                      run,
  input  logic                      srchange,
  input  logic                      loadpc,
  input  logic                      deposit,
  input  pdp8_ctrl_pkg::dp_status_t status,
  input  logic                      mem_done,
  output pdp8_ctrl_pkg::dp_ctrl_t   dp_ctrl,
  output pdp8_ctrl_pkg::mem_req_t   mem_req,
  output logic                      cpu_idle,
  output logic                      halted
);

  pdp8_ctrl_pkg::ctrl_state_t state, next_state, exec_state;
  pdp8_isa_pkg::opcode_t      opcode;

  assign opcode = pdp8_isa_pkg::opcode_t'(status.ir[11:9]);

  // Execute entry for the memory reference instructions
  always_comb begin
    case (opcode)
      pdp8_isa_pkg::OP_AND: exec_state = pdp8_ctrl_pkg::AND_1;
      pdp8_isa_pkg::OP_TAD: exec_state = pdp8_ctrl_pkg::TAD_1;
      pdp8_isa_pkg::OP_ISZ: exec_state = pdp8_ctrl_pkg::ISZ_1;
      pdp8_isa_pkg::OP_DCA: exec_state = pdp8_ctrl_pkg::DCA_1;
      pdp8_isa_pkg::OP_JMS: exec_state = pdp8_ctrl_pkg::JMS_1;
      pdp8_isa_pkg::OP_JMP: exec_state = pdp8_ctrl_pkg::JMP_1;
      default:              exec_state = pdp8_ctrl_pkg::MIC_1;
    endcase
  end

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN)
      state <= pdp8_ctrl_pkg::REG_INIT;
    else
      state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      pdp8_ctrl_pkg::REG_INIT: next_state = pdp8_ctrl_pkg::CPU_IDLE;
      pdp8_ctrl_pkg::CPU_IDLE: begin
        if (run)
          next_state = pdp8_ctrl_pkg::FETCH_1;
        else if (srchange)
          next_state = pdp8_ctrl_pkg::SR_CHG_1;
        else if (loadpc)
          next_state = pdp8_ctrl_pkg::LD_PC_1;
        else if (deposit)
          next_state = pdp8_ctrl_pkg::DEP_1;
      end
      pdp8_ctrl_pkg::SR_CHG_1: next_state = pdp8_ctrl_pkg::SR_CHG_2;
      pdp8_ctrl_pkg::SR_CHG_2: if (mem_done) next_state = pdp8_ctrl_pkg::CPU_IDLE;
      pdp8_ctrl_pkg::LD_PC_1:  next_state = pdp8_ctrl_pkg::CPU_IDLE;
      pdp8_ctrl_pkg::DEP_1:    next_state = pdp8_ctrl_pkg::DEP_2;
      pdp8_ctrl_pkg::DEP_2:    if (mem_done) next_state = pdp8_ctrl_pkg::CPU_IDLE;
      pdp8_ctrl_pkg::FETCH_1:  next_state = pdp8_ctrl_pkg::FETCH_2;
      pdp8_ctrl_pkg::FETCH_2:  if (mem_done) next_state = pdp8_ctrl_pkg::FETCH_3;
      pdp8_ctrl_pkg::FETCH_3:  next_state = pdp8_ctrl_pkg::DECODE;
      pdp8_ctrl_pkg::DECODE: begin
        if (status.ir == pdp8_isa_pkg::HALT_WORD)
          next_state = pdp8_ctrl_pkg::HALT;
        else if (opcode == pdp8_isa_pkg::OP_IOT || opcode == pdp8_isa_pkg::OP_OPR)
          next_state = pdp8_ctrl_pkg::MIC_1;   // IOT falls through as a no-op
        else
          next_state = pdp8_ctrl_pkg::CAL_EA_1;
      end
      pdp8_ctrl_pkg::CAL_EA_1:
        next_state = status.ir[pdp8_isa_pkg::IND_BIT] ? pdp8_ctrl_pkg::EA_IND_1 : exec_state;
      pdp8_ctrl_pkg::EA_IND_1: next_state = pdp8_ctrl_pkg::EA_IND_2;
      pdp8_ctrl_pkg::EA_IND_2: if (mem_done) next_state = exec_state;
      pdp8_ctrl_pkg::AND_1:    next_state = pdp8_ctrl_pkg::AND_2;
      pdp8_ctrl_pkg::AND_2:    if (mem_done) next_state = pdp8_ctrl_pkg::AND_3;
      pdp8_ctrl_pkg::TAD_1:    next_state = pdp8_ctrl_pkg::TAD_2;
      pdp8_ctrl_pkg::TAD_2:    if (mem_done) next_state = pdp8_ctrl_pkg::TAD_3;
      pdp8_ctrl_pkg::ISZ_1:    next_state = pdp8_ctrl_pkg::ISZ_2;
      pdp8_ctrl_pkg::ISZ_2:    if (mem_done) next_state = pdp8_ctrl_pkg::ISZ_3;
      pdp8_ctrl_pkg::ISZ_3:    next_state = pdp8_ctrl_pkg::ISZ_4;
      pdp8_ctrl_pkg::ISZ_4:    next_state = pdp8_ctrl_pkg::ISZ_5;
      pdp8_ctrl_pkg::ISZ_5:    if (mem_done) next_state = pdp8_ctrl_pkg::ISZ_6;
      pdp8_ctrl_pkg::DCA_1:    next_state = pdp8_ctrl_pkg::DCA_2;
      pdp8_ctrl_pkg::DCA_2:    if (mem_done) next_state = pdp8_ctrl_pkg::DCA_3;
      pdp8_ctrl_pkg::JMS_1:    next_state = pdp8_ctrl_pkg::JMS_2;
      pdp8_ctrl_pkg::JMS_2:    if (mem_done) next_state = pdp8_ctrl_pkg::JMS_3;
      pdp8_ctrl_pkg::AND_3, pdp8_ctrl_pkg::TAD_3, pdp8_ctrl_pkg::ISZ_6,
      pdp8_ctrl_pkg::DCA_3, pdp8_ctrl_pkg::JMS_3, pdp8_ctrl_pkg::JMP_1,
      pdp8_ctrl_pkg::MIC_1:    next_state = pdp8_ctrl_pkg::FETCH_1;   // Keep running
      pdp8_ctrl_pkg::HALT:     next_state = pdp8_ctrl_pkg::CPU_IDLE;
      default:                 next_state = pdp8_ctrl_pkg::REG_INIT;
    endcase
  end

  always_comb begin
    dp_ctrl  = '0;   // All selects at no change
    mem_req  = '0;
    cpu_idle = 1'b0;
    halted   = 1'b0;
    case (state)
      pdp8_ctrl_pkg::REG_INIT: begin
        dp_ctrl.ac_sel = pdp8_ctrl_pkg::AC_CLEAR;
        dp_ctrl.lk_sel = pdp8_ctrl_pkg::LK_ZERO;
        dp_ctrl.ea_sel = pdp8_ctrl_pkg::EA_ZERO;
        dp_ctrl.mb_sel = pdp8_ctrl_pkg::MB_ZERO;
      end
      pdp8_ctrl_pkg::CPU_IDLE: cpu_idle = 1'b1;
      pdp8_ctrl_pkg::SR_CHG_1: dp_ctrl.ad_sel = pdp8_ctrl_pkg::AD_SR;
      pdp8_ctrl_pkg::FETCH_1:  dp_ctrl.ad_sel = pdp8_ctrl_pkg::AD_PC;
      pdp8_ctrl_pkg::SR_CHG_2, pdp8_ctrl_pkg::FETCH_2, pdp8_ctrl_pkg::AND_2,
      pdp8_ctrl_pkg::TAD_2, pdp8_ctrl_pkg::ISZ_2: begin
        mem_req.read_enable = 1'b1;
        dp_ctrl.mb_sel      = pdp8_ctrl_pkg::MB_RD;
      end
      pdp8_ctrl_pkg::FETCH_3:  dp_ctrl.ir_load = 1'b1;
      pdp8_ctrl_pkg::LD_PC_1:  dp_ctrl.pc_sel = pdp8_ctrl_pkg::PC_SR;
      pdp8_ctrl_pkg::DEP_1: begin
        dp_ctrl.ad_sel = pdp8_ctrl_pkg::AD_PC;
        dp_ctrl.wd_sel = pdp8_ctrl_pkg::WD_SR;
      end
      pdp8_ctrl_pkg::DEP_2: begin
        mem_req.write_enable = 1'b1;
        if (mem_done)
          dp_ctrl.pc_sel = pdp8_ctrl_pkg::PC_P1;
      end
      pdp8_ctrl_pkg::CAL_EA_1:
        dp_ctrl.ea_sel = status.ir[pdp8_isa_pkg::PAGE_BIT] ? pdp8_ctrl_pkg::EA_CURPG
                                                           : pdp8_ctrl_pkg::EA_PG0;
      pdp8_ctrl_pkg::EA_IND_1, pdp8_ctrl_pkg::AND_1, pdp8_ctrl_pkg::TAD_1,
      pdp8_ctrl_pkg::ISZ_1:    dp_ctrl.ad_sel = pdp8_ctrl_pkg::AD_EA;
      pdp8_ctrl_pkg::EA_IND_2: begin
        mem_req.read_enable = 1'b1;
        dp_ctrl.mb_sel      = pdp8_ctrl_pkg::MB_RD;
        if (mem_done)
          dp_ctrl.ea_sel = pdp8_ctrl_pkg::EA_IND;   // Pointer word becomes the EA
      end
      pdp8_ctrl_pkg::AND_3: begin
        dp_ctrl.ac_sel = pdp8_ctrl_pkg::AC_AND;
        dp_ctrl.pc_sel = pdp8_ctrl_pkg::PC_P1;
      end
      pdp8_ctrl_pkg::TAD_3: begin
        dp_ctrl.ac_sel = pdp8_ctrl_pkg::AC_TAD;
        dp_ctrl.pc_sel = pdp8_ctrl_pkg::PC_P1;
      end
      pdp8_ctrl_pkg::ISZ_3:    dp_ctrl.mb_sel = pdp8_ctrl_pkg::MB_INC;
      pdp8_ctrl_pkg::ISZ_4:    dp_ctrl.wd_sel = pdp8_ctrl_pkg::WD_MB;
      pdp8_ctrl_pkg::ISZ_5, pdp8_ctrl_pkg::JMS_2: begin
        mem_req.write_enable = 1'b1;
        if (state == pdp8_ctrl_pkg::JMS_2)
          dp_ctrl.pc_sel = pdp8_ctrl_pkg::PC_JMP;
      end
      pdp8_ctrl_pkg::ISZ_6:
        dp_ctrl.pc_sel = status.mb_zero ? pdp8_ctrl_pkg::PC_P2 : pdp8_ctrl_pkg::PC_P1;
      pdp8_ctrl_pkg::DCA_1: begin
        dp_ctrl.ad_sel = pdp8_ctrl_pkg::AD_EA;
        dp_ctrl.wd_sel = pdp8_ctrl_pkg::WD_AC;
      end
      pdp8_ctrl_pkg::DCA_2: begin
        mem_req.write_enable = 1'b1;
        dp_ctrl.mb_sel       = pdp8_ctrl_pkg::MB_WD;
      end
      pdp8_ctrl_pkg::DCA_3: begin
        dp_ctrl.ac_sel = pdp8_ctrl_pkg::AC_CLEAR;
        dp_ctrl.pc_sel = pdp8_ctrl_pkg::PC_P1;
      end
      pdp8_ctrl_pkg::JMS_1: begin
        dp_ctrl.ad_sel = pdp8_ctrl_pkg::AD_EA;
        dp_ctrl.wd_sel = pdp8_ctrl_pkg::WD_PCP1;   // Return address
      end
      pdp8_ctrl_pkg::JMS_3:    dp_ctrl.pc_sel = pdp8_ctrl_pkg::PC_P1;
      pdp8_ctrl_pkg::JMP_1:    dp_ctrl.pc_sel = pdp8_ctrl_pkg::PC_JMP;
      pdp8_ctrl_pkg::MIC_1: begin
        if (opcode == pdp8_isa_pkg::OP_OPR && !status.ir[pdp8_isa_pkg::IND_BIT])
          dp_ctrl.ac_sel = pdp8_ctrl_pkg::AC_MICRO;   // Group 1 only
        dp_ctrl.pc_sel = pdp8_ctrl_pkg::PC_P1;
      end
      pdp8_ctrl_pkg::HALT:     halted = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: rtl/mem_access_timer.sv
// Core cycle timer; done pulses MEM_WAIT cycles after an enable first rises
// Enables must drop between accesses for the count to restart
`timescale 1ns/100ps

module mem_access_timer #(
  parameter int MEM_WAIT = 3
) (
  input  logic                    clock,
  input  logic                    resetN,
  input  pdp8_ctrl_pkg::mem_req_t mem_req,
  output logic                    mem_done
);

  localparam int CW = $clog2(MEM_WAIT + 1);

  logic [CW-1:0] count;
  logic          busy;

  assign busy = mem_req.read_enable | mem_req.write_enable;

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      count    <= '0;
      mem_done <= 1'b0;
    end else if (!busy) begin
      count    <= '0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= (count == CW'(MEM_WAIT - 1));
      if (count != CW'(MEM_WAIT))
        count <= count + 1'b1;   // Saturates so done fires once
    end
  end

endmodule

// File: rtl/core_memory.sv
// 4K word store, contents undefined until written
// Writes commit on the done pulse; read data follows addr while the read is enabled
`timescale 1ns/100ps

module core_memory (
  input  logic                    clock,
  input  pdp8_ctrl_pkg::mem_req_t mem_req,
  input  logic                    mem_done,
  input  pdp8_isa_pkg::addr_t     addr,
  input  pdp8_isa_pkg::word_t     wr_data,
  output pdp8_isa_pkg::word_t     rd_data
);

  localparam int DEPTH = 2 ** $bits(pdp8_isa_pkg::addr_t);

  pdp8_isa_pkg::word_t mem [0:DEPTH-1];

  always_ff @(posedge clock) begin
    if (mem_req.write_enable && mem_done)
      mem[addr] <= wr_data;
  end

  // Valid from the cycle after the enable rises, so always by the done pulse
  always_ff @(posedge clock) begin
    if (mem_req.read_enable)
      rd_data <= mem[addr];
  end

endmodule

// File: rtl/pdp8_datapath.sv
// Register file and arithmetic of the processor; TAD and IAC carries complement the link
// Only PC has a hardware reset, the other registers are cleared by REG_INIT
`timescale 1ns/100ps

module pdp8_datapath (
  input  logic                      clock,
  input  logic                      resetN,
  input  pdp8_ctrl_pkg::dp_ctrl_t   dp_ctrl,
  input  pdp8_isa_pkg::word_t       switch_reg,
  input  pdp8_ctrl_pkg::disp_sel_t  disp_sel,
  input  pdp8_isa_pkg::word_t       rd_data,
  input  logic                      mem_done,
  output pdp8_ctrl_pkg::dp_status_t status,
  output pdp8_isa_pkg::addr_t       mem_addr,
  output pdp8_isa_pkg::word_t       wr_data,
  output pdp8_isa_pkg::word_t       display
);

  pdp8_isa_pkg::word_t     ac, ir, mb, micro_ac;
  pdp8_isa_pkg::addr_t     pc, ea;
  pdp8_isa_pkg::page_off_t offset;
  logic                    link, micro_lk;
  logic [12:0]             tad_sum;

  assign offset  = ir[6:0];
  assign tad_sum = {1'b0, ac} + {1'b0, mb};

  // Group-1 sequence: clear, complement, increment
  always_comb begin
    micro_ac = ac;
    micro_lk = link;
    if (ir[pdp8_isa_pkg::CLA_BIT]) micro_ac = '0;
    if (ir[pdp8_isa_pkg::CLL_BIT]) micro_lk = 1'b0;
    if (ir[pdp8_isa_pkg::CMA_BIT]) micro_ac = ~micro_ac;
    if (ir[pdp8_isa_pkg::CML_BIT]) micro_lk = ~micro_lk;
    if (ir[pdp8_isa_pkg::IAC_BIT]) {micro_lk, micro_ac} = {micro_lk, micro_ac} + 13'd1;
  end

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      pc <= '0;
    end else begin
      case (dp_ctrl.pc_sel)
        pdp8_ctrl_pkg::PC_SR:  pc <= switch_reg;
        pdp8_ctrl_pkg::PC_P1:  pc <= pc + 12'd1;
        pdp8_ctrl_pkg::PC_P2:  pc <= pc + 12'd2;   // Skip
        pdp8_ctrl_pkg::PC_JMP: pc <= ea;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    case (dp_ctrl.ac_sel)
      pdp8_ctrl_pkg::AC_CLEAR: ac <= '0;
      pdp8_ctrl_pkg::AC_AND:   ac <= ac & mb;
      pdp8_ctrl_pkg::AC_TAD: begin
        ac   <= tad_sum[11:0];
        link <= link ^ tad_sum[12];
      end
      pdp8_ctrl_pkg::AC_MICRO: begin
        ac   <= micro_ac;
        link <= micro_lk;
      end
      default: ;
    endcase
    if (dp_ctrl.lk_sel == pdp8_ctrl_pkg::LK_ZERO)
      link <= 1'b0;

    case (dp_ctrl.mb_sel)
      pdp8_ctrl_pkg::MB_ZERO: mb <= '0;
      pdp8_ctrl_pkg::MB_RD:   if (mem_done) mb <= rd_data;
      pdp8_ctrl_pkg::MB_INC:  mb <= mb + 12'd1;
      pdp8_ctrl_pkg::MB_WD:   mb <= wr_data;
      default: ;
    endcase

    case (dp_ctrl.ea_sel)
      pdp8_ctrl_pkg::EA_ZERO:  ea <= '0;
      pdp8_ctrl_pkg::EA_PG0:   ea <= {5'b0, offset};
      pdp8_ctrl_pkg::EA_CURPG: ea <= {pc[11:7], offset};   // Page of the instruction
      pdp8_ctrl_pkg::EA_IND:   ea <= rd_data;
      default: ;
    endcase

    case (dp_ctrl.ad_sel)
      pdp8_ctrl_pkg::AD_SR: mem_addr <= switch_reg;
      pdp8_ctrl_pkg::AD_PC: mem_addr <= pc;
      pdp8_ctrl_pkg::AD_EA: mem_addr <= ea;
      default: ;
    endcase

    case (dp_ctrl.wd_sel)
      pdp8_ctrl_pkg::WD_SR:   wr_data <= switch_reg;
      pdp8_ctrl_pkg::WD_MB:   wr_data <= mb;
      pdp8_ctrl_pkg::WD_AC:   wr_data <= ac;
      pdp8_ctrl_pkg::WD_PCP1: wr_data <= pc + 12'd1;
      default: ;
    endcase

    if (dp_ctrl.ir_load)
      ir <= mb;
  end

  assign status.ir      = ir;
  assign status.mb_zero = (mb == '0);

  always_comb begin
    case (disp_sel)
      pdp8_ctrl_pkg::DISP_PC: display = pc;
      pdp8_ctrl_pkg::DISP_AC: display = ac;
      default:                display = mb;
    endcase
  end

endmodule

// File: rtl/pdp8_top.sv
// Processor top with front-panel strobes, switch register and display select
// MEM_WAIT sets the core memory cycle in clocks and must be 1 or more
`timescale 1ns/100ps

module pdp8_top #(
  parameter int MEM_WAIT = 3
) (
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     run,
  input  logic                     srchange,
  input  logic                     loadpc,
  input  logic                     deposit,
  input  pdp8_isa_pkg::word_t      switch_reg,
  input  pdp8_ctrl_pkg::disp_sel_t disp_sel,
  output pdp8_isa_pkg::word_t      display,
  output logic                     cpu_idle,
  output logic                     halted
);

  pdp8_ctrl_pkg::dp_ctrl_t   dp_ctrl;
  pdp8_ctrl_pkg::mem_req_t   mem_req;
  pdp8_ctrl_pkg::dp_status_t status;
  pdp8_isa_pkg::addr_t       mem_addr;
  pdp8_isa_pkg::word_t       wr_data, rd_data;
  logic                      mem_done;

  pdp8_controller u_ctrl (
    .clock(clock), .resetN(resetN), .run(run), .srchange(srchange),
    .loadpc(loadpc), .deposit(deposit), .status(status), .mem_done(mem_done),
    .dp_ctrl(dp_ctrl), .mem_req(mem_req), .cpu_idle(cpu_idle), .halted(halted)
  );

  mem_access_timer #(.MEM_WAIT(MEM_WAIT)) u_timer (
    .clock(clock), .resetN(resetN), .mem_req(mem_req), .mem_done(mem_done)
  );

  core_memory u_mem (
    .clock(clock), .mem_req(mem_req), .mem_done(mem_done), .addr(mem_addr),
    .wr_data(wr_data), .rd_data(rd_data)
  );

  pdp8_datapath u_dp (
    .clock(clock), .resetN(resetN), .dp_ctrl(dp_ctrl), .switch_reg(switch_reg),
    .disp_sel(disp_sel), .rd_data(rd_data), .mem_done(mem_done), .status(status),
    .mem_addr(mem_addr), .wr_data(wr_data), .display(display)
  );

endmodule

// File: sim/pdp8_asserts.sv
// Protocol properties of the controller outputs, bound into pdp8_controller
// Checked only while resetN is high
`timescale 1ns/100ps

module pdp8_asserts (
  input logic                    clock,
  input logic                    resetN,
  input pdp8_ctrl_pkg::mem_req_t mem_req,
  input logic                    cpu_idle,
  input logic                    halted
);

  // One core access at a time
  read_write_exclusive: assert property (@(posedge clock) disable iff (!resetN)
    !(mem_req.read_enable && mem_req.write_enable))
    else $error("Read and write enables are high together");

  idle_halt_exclusive: assert property (@(posedge clock) disable iff (!resetN)
    !(cpu_idle && halted))
    else $error("cpu_idle and halted are high together");

  halt_then_idle: assert property (@(posedge clock) disable iff (!resetN)
    halted |=> cpu_idle)
    else $error("cpu_idle did not follow the halt pulse");

endmodule

bind pdp8_controller pdp8_asserts u_asserts (
  .clock(clock), .resetN(resetN), .mem_req(mem_req), .cpu_idle(cpu_idle), .halted(halted)
);

// File: sim/pdp8_tb.sv
// Front-panel testbench driven by sim/pdp8_tests.txt; run it from the project root
// Test file numbers are octal, comment lines start with a lone # token
`timescale 1ns/100ps

module pdp8_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                     clock;
  logic                     resetN;
  logic                     run;
  logic                     srchange;
  logic                     loadpc;
  logic                     deposit;
  pdp8_isa_pkg::word_t      switch_reg;
  pdp8_ctrl_pkg::disp_sel_t disp_sel;
  pdp8_isa_pkg::word_t      display;
  logic                     cpu_idle;
  logic                     halted;
  int                       check_count;

  pdp8_top #(.MEM_WAIT(3)) uut (
    .clock(clock), .resetN(resetN), .run(run), .srchange(srchange), .loadpc(loadpc),
    .deposit(deposit), .switch_reg(switch_reg), .disp_sel(disp_sel), .display(display),
    .cpu_idle(cpu_idle), .halted(halted)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input pdp8_isa_pkg::word_t expected,
                            input pdp8_isa_pkg::word_t actual);
    check_count++;
    if (actual !== expected)
      stop_on_error($sformatf("Mismatch at time %0t: %s expected %04o, got %04o",
                              $time, name, expected, actual));
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      stop_on_error($sformatf("Mismatch at time %0t: %s expected %b, got %b",
                              $time, name, expected, actual));
  endtask

  task automatic wait_idle(input logic [7:0] cmd);
    int cycles;
    cycles = 0;
    while (cpu_idle !== 1'b1) begin
      @(negedge clock);
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
        stop_on_error($sformatf("Timeout: cpu_idle did not return after command %c", cmd));
    end
  endtask

  task automatic wait_halt();
    int cycles;
    cycles = 0;
    while (halted !== 1'b1) begin
      @(negedge clock);
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
        stop_on_error("Timeout: the program did not reach a halt");
    end
  endtask

  // One-cycle strobe, sampled by the rising edge in between
  task automatic press_key(input logic [7:0] cmd, input pdp8_isa_pkg::word_t value);
    @(negedge clock);
    switch_reg = value;
    case (cmd)
      "R":     run = 1'b1;
      "E":     srchange = 1'b1;
      "P":     loadpc = 1'b1;
      default: deposit = 1'b1;
    endcase
    @(negedge clock);
    run      = 1'b0;
    srchange = 1'b0;
    loadpc   = 1'b0;
    deposit  = 1'b0;
  endtask

  task automatic read_display(input pdp8_ctrl_pkg::disp_sel_t sel,
                              output pdp8_isa_pkg::word_t value);
    @(negedge clock);
    disp_sel = sel;
    @(negedge clock);
    value = display;
  endtask

  task automatic read_operand(input int fd, input logic [7:0] cmd,
                              output pdp8_isa_pkg::word_t value);
    int code;
    code = $fscanf(fd, "%o", value);
    if (code != 1)
      stop_on_error($sformatf("Missing octal operand after command %c", cmd));
  endtask

  initial begin
    int                  fd;
    int                  code;
    logic [7:0]          cmd;
    logic [8*128-1:0]    comment;
    pdp8_isa_pkg::word_t arg;
    pdp8_isa_pkg::word_t expected;
    pdp8_isa_pkg::word_t value;
    resetN      = 1'b0;
    run         = 1'b0;
    srchange    = 1'b0;
    loadpc      = 1'b0;
    deposit     = 1'b0;
    switch_reg  = '0;
    disp_sel    = pdp8_ctrl_pkg::DISP_PC;
    check_count = 0;
    repeat (3) @(negedge clock);
    resetN = 1'b1;
    wait_idle("I");
    check_flag("halted", 1'b0, halted);

    fd = $fopen("sim/pdp8_tests.txt", "r");
    if (fd == 0)
      stop_on_error("Could not open the test file sim/pdp8_tests.txt");
    code = $fscanf(fd, "%s", cmd);
    while (code == 1) begin
      case (cmd)
        "#": code = $fgets(comment, fd);
        "P", "D": begin
          read_operand(fd, cmd, arg);
          press_key(cmd, arg);
          wait_idle(cmd);
        end
        "E": begin
          read_operand(fd, cmd, arg);
          read_operand(fd, cmd, expected);
          press_key(cmd, arg);
          wait_idle(cmd);
          read_display(pdp8_ctrl_pkg::DISP_MB, value);
          check_word($sformatf("MB from %04o", arg), expected, value);
        end
        "R": begin
          press_key(cmd, switch_reg);
          wait_halt();
          @(negedge clock);
          check_flag("cpu_idle", 1'b1, cpu_idle);   // One cycle after the halt pulse
          check_flag("halted", 1'b0, halted);
        end
        "A": begin
          read_operand(fd, cmd, expected);
          read_display(pdp8_ctrl_pkg::DISP_AC, value);
          check_word("AC", expected, value);
        end
        "C": begin
          read_operand(fd, cmd, expected);
          read_display(pdp8_ctrl_pkg::DISP_PC, value);
          check_word("PC", expected, value);
        end
        default: stop_on_error($sformatf("Unknown command %c in the test file", cmd));
      endcase
      code = $fscanf(fd, "%s", cmd);
    end
    $fclose(fd);

    if (check_count == 0) begin
      stop_on_error("The test file held no checks");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// File: sim/pdp8_tests.txt
# Commands: P addr, D word, E addr mb, R, A ac, C pc; all numbers octal
# Several commands may share a line; a comment line starts with a lone #
# Reset state
C 0000
A 0000
# Deposit at consecutive addresses, then examine
P 0200
D 1234
D 4321
D 7777
C 0203
E 0200 1234
E 0201 4321
E 0202 7777
# TAD with carry, AND, DCA on page-zero data, then HLT
P 0050 D 2345 D 6543 D 7070 D 0000
P 0200 D 7300 D 1050 D 1051 D 0052 D 3053 D 7402
P 0200 R
C 0205
A 0000
E 0053 1010
# ISZ skip on zero, direct JMP, JMS and return by JMP I
P 0450 D 7776 D 0000
P 0460 D 0000 D 2251 D 5660
P 0400 D 7200 D 2250 D 2250 D 7402 D 5206 D 7402 D 4260 D 7402
P 0400 R
C 0407
E 0450 0000
E 0451 0001
E 0460 0407
# Current-page direct, current-page indirect and page-zero indirect operands
P 1250 D 0123 D 0060
P 0060 D 0456
P 7070 D 0001
P 1200 D 7300 D 1250 D 1651 D 1452 D 3253 D 7402
P 1200 R
C 1205
A 0000
E 1253 0602
# Group-1 microinstructions, then a TAD that carries out of AC
P 1450 D 0005 D 0000 D 1111
P 1400 D 7300 D 1250 D 7041 D 3251 D 1250 D 7241 D 3252 D 7240 D 1250 D 7402
P 1400 R
C 1411
A 0004
E 1451 7773
E 1452 0000

// File: compile.f
rtl/pdp8_isa_pkg.sv
rtl/pdp8_ctrl_pkg.sv
rtl/pdp8_controller.sv
rtl/mem_access_timer.sv
rtl/core_memory.sv
rtl/pdp8_datapath.sv
rtl/pdp8_top.sv
sim/pdp8_asserts.sv
sim/pdp8_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module pdp8_tb -f compile.f
output=$(./obj_dir/Vpdp8_tb 2>&1) || true
echo "$output"
if echo "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi
